// ==== design/openadc_pkg.sv ====
package openadc_pkg;

   localparam int adc_width_c = 12;   // ADC sample width
   localparam int freq_width_c = 32;  // frequency counts and change limit

   // byte-wide register map, multi-byte entries use the byte count
   typedef enum logic [7:0] {
      addr_gain         = 8'h00,
      addr_settings     = 8'h01,
      addr_status       = 8'h02,
      addr_trig_level   = 8'h05,  // 2 bytes, bit 11 selects polarity
      addr_arm          = 8'h06,  // write strobe only
      addr_led_select   = 8'h07,
      addr_extclk_freq  = 8'h08,  // 4 bytes, read only
      addr_extclk_limit = 8'h09   // 4 bytes
   } reg_addr_e;

   // what the two panel LEDs show
   typedef enum logic [1:0] {
      led_normal    = 2'd0,
      led_heartbeat = 2'd1,
      led_extclk    = 2'd2,
      led_gate      = 2'd3
   } led_sel_e;

   // bit positions inside the status register
   typedef enum logic [2:0] {
      status_armed         = 3'd0,
      status_triggered     = 3'd1,
      status_pll           = 3'd4,
      status_extclk_change = 3'd5
   } status_bit_e;

   // settings register bits
   localparam int set_soft_reset_c = 0;
   localparam int set_data_source_c = 1;    // 1 = ADC pins, 0 = test pattern
   localparam int set_mon_disable_c = 2;

endpackage

// ==== design/adc_reg_bank.sv ====
`timescale 1ns/10ps

module adc_reg_bank #(
   parameter int p_bytecnt_size = 7
) (
   input  logic                                    clk_usb,
   input  logic                                    reset,
   input  logic [7:0]                              reg_address_i,
   input  logic [p_bytecnt_size-1:0]               reg_bytecnt_i,
   input  logic [7:0]                              reg_datai_i,
   input  logic                                    reg_write_i,
   input  logic                                    armed_i,
   input  logic                                    triggered_i,
   input  logic                                    pll_status_i,
   input  logic                                    extclk_change_i,
   input  logic [openadc_pkg::freq_width_c-1:0]    extclk_freq_i,
   output logic [7:0]                              reg_datao_o,
   output logic                                    rst_o,
   output logic                                    arm_o,
   output logic                                    data_source_o,
   output logic                                    monitor_disable_o,
   output logic [7:0]                              gain_o,
   output logic [openadc_pkg::adc_width_c-1:0]     trig_level_o,
   output openadc_pkg::led_sel_e                   led_select_o,
   output logic [openadc_pkg::freq_width_c-1:0]    extclk_limit_o
);

   openadc_pkg::reg_addr_e addr;
   logic [2:0] settings;
   logic [7:0] status;
   logic       byte_ok;      // byte count inside a 4-byte register
   logic       arm_hit;

   assign addr = openadc_pkg::reg_addr_e'(reg_address_i);
   assign byte_ok = (reg_bytecnt_i < 4);

   // soft reset bit clears itself through the combined reset
   assign rst_o = reset | settings[openadc_pkg::set_soft_reset_c];
   assign data_source_o = settings[openadc_pkg::set_data_source_c];
   assign monitor_disable_o = settings[openadc_pkg::set_mon_disable_c];

   always_ff @(posedge clk_usb) begin
      if (rst_o) begin
         settings <= '0;
         gain_o <= '0;
         trig_level_o <= '0;
         led_select_o <= openadc_pkg::led_normal;
         extclk_limit_o <= '0;
      end else if (reg_write_i) begin
         case (addr)
            openadc_pkg::addr_settings:   settings <= reg_datai_i[2:0];
            openadc_pkg::addr_gain:       gain_o <= reg_datai_i;
            openadc_pkg::addr_led_select:
               led_select_o <= openadc_pkg::led_sel_e'(reg_datai_i[1:0]);
            openadc_pkg::addr_trig_level: begin
               if (reg_bytecnt_i == 0)
                  trig_level_o[7:0] <= reg_datai_i;
               else if (reg_bytecnt_i == 1)   // upper nibble only
                  trig_level_o[openadc_pkg::adc_width_c-1:8] <=
                     reg_datai_i[openadc_pkg::adc_width_c-9:0];
            end
            openadc_pkg::addr_extclk_limit: begin
               if (byte_ok)
                  extclk_limit_o[8*reg_bytecnt_i[1:0] +: 8] <= reg_datai_i;
            end
            default: ;
         endcase
      end
   end

   // registered arm strobe for each write cycle
   assign arm_hit = reg_write_i && (addr == openadc_pkg::addr_arm);

   always_ff @(posedge clk_usb) begin
      if (rst_o)
         arm_o <= 1'b0;
      else
         arm_o <= arm_hit;
   end

   always_comb begin
      status = '0;
      status[openadc_pkg::status_armed] = armed_i;
      status[openadc_pkg::status_triggered] = triggered_i;
      status[openadc_pkg::status_pll] = pll_status_i;
      status[openadc_pkg::status_extclk_change] = extclk_change_i;
   end

   // read-back mux
   always_comb begin
      reg_datao_o = '0;
      case (addr)
         openadc_pkg::addr_settings:   reg_datao_o = {5'b0, settings};
         openadc_pkg::addr_status:     reg_datao_o = status;
         openadc_pkg::addr_gain:       reg_datao_o = gain_o;
         openadc_pkg::addr_led_select: reg_datao_o = {6'b0, led_select_o};
         openadc_pkg::addr_trig_level: begin
            if (reg_bytecnt_i == 0)
               reg_datao_o = trig_level_o[7:0];
            else if (reg_bytecnt_i == 1)
               reg_datao_o = {4'b0, trig_level_o[openadc_pkg::adc_width_c-1:8]};
         end
         openadc_pkg::addr_extclk_freq: begin
            if (byte_ok)
               reg_datao_o = extclk_freq_i[8*reg_bytecnt_i[1:0] +: 8];
         end
         openadc_pkg::addr_extclk_limit: begin
            if (byte_ok)
               reg_datao_o = extclk_limit_o[8*reg_bytecnt_i[1:0] +: 8];
         end
         default: ;
      endcase
   end

   // a strobe longer than one cycle would rearm the trigger unit
   arm_single_cycle: assert property (@(posedge clk_usb) disable iff (rst_o)
      arm_o |=> !arm_o);

endmodule

// ==== design/adc_timebase.sv ====
`timescale 1ns/10ps

module adc_timebase #(
   parameter int p_gate_bits = 23
) (
   input  logic clk_usb,
   input  logic reset,
   output logic gate_o,
   output logic heartbeat_o,
   output logic flash_pattern_o
);

   logic [p_gate_bits+2:0] timer;
   logic                   gate_bit_q;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer <= '0;
         gate_bit_q <= 1'b0;
         gate_o <= 1'b0;
         flash_pattern_o <= 1'b0;
      end else begin
         timer <= timer + 1'b1;
         gate_bit_q <= timer[p_gate_bits-1];
         gate_o <= timer[p_gate_bits-1] && !gate_bit_q;   // once per 2**p_gate_bits
         if (timer[p_gate_bits+2])
            flash_pattern_o <= ~timer[p_gate_bits];   // blink in upper half only
      end
   end

   assign heartbeat_o = timer[p_gate_bits+1];

   // monitor latches one count per window
   gate_single_cycle: assert property (@(posedge clk_usb) disable iff (reset)
      gate_o |=> !gate_o);

endmodule

// ==== design/extclk_monitor.sv ====
`timescale 1ns/10ps

module extclk_monitor (
   input  logic                                    clk_usb,
   input  logic                                    reset,
   input  logic                                    ext_clk_i,
   input  logic                                    gate_i,
   input  logic                                    monitor_disable_i,
   input  logic [openadc_pkg::freq_width_c-1:0]    limit_i,
   output logic                                    ext_clk_sync_o,
   output logic [openadc_pkg::freq_width_c-1:0]    freq_o,
   output logic                                    change_o
);

   logic                                  sync_meta;
   logic                                  sync_q;
   logic                                  rise;
   logic [openadc_pkg::freq_width_c-1:0]  count;
   logic [openadc_pkg::freq_width_c-1:0]  diff;

   // two-flop synchronizer, third flop for edge detect
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         sync_meta <= 1'b0;
         ext_clk_sync_o <= 1'b0;
         sync_q <= 1'b0;
      end else begin
         sync_meta <= ext_clk_i;
         ext_clk_sync_o <= sync_meta;
         sync_q <= ext_clk_sync_o;
      end
   end

   assign rise = ext_clk_sync_o && !sync_q;

   // distance between new and latched count
   assign diff = (count > freq_o) ? (count - freq_o) : (freq_o - count);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         count <= '0;
         freq_o <= '0;
      end else if (gate_i) begin
         freq_o <= count;
         count <= {{(openadc_pkg::freq_width_c-1){1'b0}}, rise};   // edge on gate counts
      end else if (rise) begin
         count <= count + 1'b1;
      end
   end

   // sticky until monitor disable is set
   always_ff @(posedge clk_usb) begin
      if (reset)
         change_o <= 1'b0;
      else if (monitor_disable_i)
         change_o <= 1'b0;
      else if (gate_i && (freq_o != '0) && (diff > limit_i))
         change_o <= 1'b1;
   end

endmodule

// ==== design/adc_level_trigger.sv ====
`timescale 1ns/10ps

module adc_level_trigger (
   input  logic                                 clk_usb,
   input  logic                                 reset,
   input  logic [openadc_pkg::adc_width_c-1:0]  adc_data_i,
   input  logic                                 data_source_i,
   input  logic [openadc_pkg::adc_width_c-1:0]  level_i,
   input  logic                                 arm_i,
   output logic                                 trigger_o,
   output logic                                 armed_o,
   output logic                                 triggered_o
);

   typedef enum logic [1:0] {
      trig_idle,
      trig_armed,
      trig_done
   } trig_state_e;

   trig_state_e state;
   logic [openadc_pkg::adc_width_c-1:0] pattern;
   logic [openadc_pkg::adc_width_c-1:0] sample_pre;
   logic [openadc_pkg::adc_width_c-1:0] sample;
   logic                                hit;

   // counting test pattern
   always_ff @(posedge clk_usb) begin
      if (reset)
         pattern <= '0;
      else
         pattern <= pattern + 1'b1;
   end

   // two resample stages
   always_ff @(posedge clk_usb) begin
      sample_pre <= data_source_i ? adc_data_i : pattern;
      sample <= sample_pre;
   end

   // msb of level picks the polarity
   assign hit = level_i[openadc_pkg::adc_width_c-1] ? (sample > level_i) :
                                                      (sample < level_i);

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state <= trig_idle;
         trigger_o <= 1'b0;
      end else begin
         trigger_o <= 1'b0;
         if (arm_i) begin
            state <= trig_armed;   // rearm also clears triggered
         end else if (state == trig_armed && hit) begin
            state <= trig_done;
            trigger_o <= 1'b1;
         end
      end
   end

   assign armed_o = (state == trig_armed);
   assign triggered_o = (state == trig_done);

   // one pulse per arm
   trigger_one_shot: assert property (@(posedge clk_usb) disable iff (reset)
      trigger_o |=> !trigger_o);

endmodule

// ==== design/panel_drive.sv ====
`timescale 1ns/10ps

module panel_drive (
   input  logic                  clk_usb,
   input  logic                  reset,
   input  openadc_pkg::led_sel_e led_select_i,
   input  logic [7:0]            gain_i,
   input  logic                  armed_i,
   input  logic                  triggered_i,
   input  logic                  heartbeat_i,
   input  logic                  gate_i,
   input  logic                  flash_i,
   input  logic                  ext_clk_sync_i,
   input  logic                  extclk_change_i,
   output logic                  led_armed_o,
   output logic                  led_capture_o,
   output logic                  amp_gain_o
);

   logic [8:0] pwm_acc;

   always_comb begin
      if (extclk_change_i) begin   // clock alarm overrides the select
         led_armed_o = flash_i;
         led_capture_o = flash_i;
      end else begin
         case (led_select_i)
            openadc_pkg::led_heartbeat: begin
               led_armed_o = heartbeat_i;
               led_capture_o = gate_i;
            end
            openadc_pkg::led_extclk: begin
               led_armed_o = ext_clk_sync_i;
               led_capture_o = extclk_change_i;
            end
            openadc_pkg::led_gate: begin
               led_armed_o = gate_i;
               led_capture_o = flash_i;
            end
            default: begin
               led_armed_o = armed_i;
               led_capture_o = triggered_i;
            end
         endcase
      end
   end

   // carry out gives gain pulses per 256 cycles
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= pwm_acc[7:0] + gain_i;
   end

   assign amp_gain_o = pwm_acc[8];

endmodule

// ==== design/openadc_interface.sv ====
`timescale 1ns/10ps

module openadc_interface #(
   parameter int p_bytecnt_size = 7,
   parameter int p_gate_bits = 23
) (
   input  logic                                 clk_usb,
   input  logic                                 reset,
   input  logic [openadc_pkg::adc_width_c-1:0]  adc_data_i,
   input  logic                                 ext_clk_i,
   input  logic                                 pll_status_i,
   input  logic [7:0]                           reg_address_i,
   input  logic [p_bytecnt_size-1:0]            reg_bytecnt_i,
   input  logic [7:0]                           reg_datai_i,
   input  logic                                 reg_write_i,
   output logic [7:0]                           reg_datao_o,
   output logic                                 reset_o,
   output logic                                 trigger_adc_o,
   output logic                                 amp_gain_o,
   output logic                                 led_armed_o,
   output logic                                 led_capture_o,
   output logic                                 freq_measure_o,
   output logic                                 flash_pattern_o
);

   logic                                  rst;
   logic                                  arm;
   logic                                  armed;
   logic                                  triggered;
   logic                                  data_source;
   logic                                  monitor_disable;
   logic [7:0]                            gain;
   logic [openadc_pkg::adc_width_c-1:0]   trig_level;
   openadc_pkg::led_sel_e                 led_select;
   logic [openadc_pkg::freq_width_c-1:0]  extclk_limit;
   logic [openadc_pkg::freq_width_c-1:0]  extclk_freq;
   logic                                  extclk_change;
   logic                                  ext_clk_sync;
   logic                                  gate;
   logic                                  heartbeat;

   assign reset_o = rst;
   assign freq_measure_o = gate;

   adc_reg_bank #(
      .p_bytecnt_size      (p_bytecnt_size)
   ) u_reg_bank (
      .clk_usb             (clk_usb),
      .reset               (reset),
      .reg_address_i       (reg_address_i),
      .reg_bytecnt_i       (reg_bytecnt_i),
      .reg_datai_i         (reg_datai_i),
      .reg_write_i         (reg_write_i),
      .armed_i             (armed),
      .triggered_i         (triggered),
      .pll_status_i        (pll_status_i),
      .extclk_change_i     (extclk_change),
      .extclk_freq_i       (extclk_freq),
      .reg_datao_o         (reg_datao_o),
      .rst_o               (rst),
      .arm_o               (arm),
      .data_source_o       (data_source),
      .monitor_disable_o   (monitor_disable),
      .gain_o              (gain),
      .trig_level_o        (trig_level),
      .led_select_o        (led_select),
      .extclk_limit_o      (extclk_limit)
   );

   adc_timebase #(
      .p_gate_bits         (p_gate_bits)
   ) u_timebase (
      .clk_usb             (clk_usb),
      .reset               (rst),
      .gate_o              (gate),
      .heartbeat_o         (heartbeat),
      .flash_pattern_o     (flash_pattern_o)
   );

   extclk_monitor u_extclk_monitor (
      .clk_usb             (clk_usb),
      .reset               (rst),
      .ext_clk_i           (ext_clk_i),
      .gate_i              (gate),
      .monitor_disable_i   (monitor_disable),
      .limit_i             (extclk_limit),
      .ext_clk_sync_o      (ext_clk_sync),
      .freq_o              (extclk_freq),
      .change_o            (extclk_change)
   );

   adc_level_trigger u_level_trigger (
      .clk_usb             (clk_usb),
      .reset               (rst),
      .adc_data_i          (adc_data_i),
      .data_source_i       (data_source),
      .level_i             (trig_level),
      .arm_i               (arm),
      .trigger_o           (trigger_adc_o),
      .armed_o             (armed),
      .triggered_o         (triggered)
   );

   panel_drive u_panel_drive (
      .clk_usb             (clk_usb),
      .reset               (rst),
      .led_select_i        (led_select),
      .gain_i              (gain),
      .armed_i             (armed),
      .triggered_i         (triggered),
      .heartbeat_i         (heartbeat),
      .gate_i              (gate),
      .flash_i             (flash_pattern_o),
      .ext_clk_sync_i      (ext_clk_sync),
      .extclk_change_i     (extclk_change),
      .led_armed_o         (led_armed_o),
      .led_capture_o       (led_capture_o),
      .amp_gain_o          (amp_gain_o)
   );

endmodule

// ==== tests/tb_vectors.svh ====
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// trigger rows: name, level register, data source, samples, expected pulses
// level bit 11 set means fire above the level, clear means below
localparam int num_rows = 6;
string       vec_name   [num_rows] = '{"above_hit", "above_miss", "below_hit",
                                       "below_miss", "multi_hit", "pattern"};
logic [11:0] vec_level  [num_rows] = '{12'h900, 12'hc00, 12'h400, 12'h200, 12'h880, 12'h864};
logic        vec_source [num_rows] = '{1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b0};
int          vec_trig   [num_rows] = '{1, 0, 1, 0, 1, 1};
logic [11:0] vec_samples [num_rows][8] = '{
   '{12'h064, 12'h0c8, 12'h800, 12'h8f0, 12'ha00, 12'h300, 12'h100, 12'h050},
   '{12'h100, 12'hbf0, 12'h400, 12'h800, 12'h000, 12'h7ff, 12'hbe0, 12'h020},
   '{12'hff0, 12'h800, 12'h404, 12'h3f0, 12'h500, 12'h600, 12'h404, 12'hf00},
   '{12'h200, 12'h300, 12'hff0, 12'h204, 12'h800, 12'h210, 12'h400, 12'h2f0},
   '{12'h700, 12'h900, 12'h950, 12'hff0, 12'h700, 12'ha00, 12'h884, 12'h100},
   '{12'h000, 12'h000, 12'h000, 12'h000, 12'h000, 12'h000, 12'h000, 12'h000}
};

// register rows written then read back
localparam int num_regs = 8;
logic [7:0] regs_addr [num_regs] = '{openadc_pkg::addr_gain, openadc_pkg::addr_trig_level,
   openadc_pkg::addr_trig_level, openadc_pkg::addr_extclk_limit,
   openadc_pkg::addr_extclk_limit, openadc_pkg::addr_extclk_limit,
   openadc_pkg::addr_extclk_limit, openadc_pkg::addr_led_select};
logic [6:0] regs_cnt  [num_regs] = '{7'd0, 7'd0, 7'd1, 7'd0, 7'd1, 7'd2, 7'd3, 7'd0};
logic [7:0] regs_data [num_regs] = '{8'ha5, 8'h3c, 8'h0b, 8'h11, 8'h22, 8'h33, 8'h44, 8'h02};

int pwm_gains [5] = '{0, 1, 77, 128, 255};

`endif

// ==== tests/tb_openadc_interface.sv ====
`timescale 1ns/10ps

module tb_openadc_interface;

   `include "tb_vectors.svh"

   localparam int clk_period = 40;
   localparam int gate_cycles = 256;   // 2**8 with the gate override

   logic        clk_usb = 1'b0;
   logic        reset;
   logic [11:0] adc_data_i;
   logic        ext_clk_i;
   logic        pll_status_i;
   logic [7:0]  reg_address_i;
   logic [6:0]  reg_bytecnt_i;
   logic [7:0]  reg_datai_i;
   logic        reg_write_i;
   logic [7:0]  reg_datao_o;
   logic        reset_o;
   logic        trigger_adc_o;
   logic        amp_gain_o;
   logic        led_armed_o;
   logic        led_capture_o;
   logic        freq_measure_o;
   logic        flash_pattern_o;

   logic [31:0] lfsr = 32'h8088b5e0;
   int          trig_count = 0;
   int          gate_count = 0;
   int          ext_half = 2;   // ext clock half period in clk_usb cycles
   int          ext_cnt = 0;
   string       cur_test;
   int          test_errors;
   int          tests_run;
   int          tests_failed;

   openadc_interface #(.p_gate_bits(8)) uut (.*);

   always #(clk_period / 2) clk_usb = ~clk_usb;

   always @(posedge clk_usb) begin
      if (ext_cnt + 1 >= ext_half) begin
         ext_cnt <= 0;
         ext_clk_i <= ~ext_clk_i;
      end else begin
         ext_cnt <= ext_cnt + 1;
      end
   end

   // pulse counters sampled away from the active edge
   always @(negedge clk_usb) begin
      if (trigger_adc_o)
         trig_count++;
      if (freq_measure_o)
         gate_count++;
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_noise(input int nbits, output logic [11:0] r);
      r = '0;
      for (int b = 0; b < nbits; b++) begin
         lfsr = lfsr_step(lfsr);
         r = {r[10:0], lfsr[0]};
      end
   endtask

   task automatic start_test(input string name);
      cur_test = name;
      test_errors = 0;
   endtask

   task automatic finish_test();
      tests_run++;
      if (test_errors == 0) begin
         $display("PASS %s", cur_test);
      end else begin
         tests_failed++;
         $display("FAIL %s with %0d errors", cur_test, test_errors);
      end
   endtask

   task automatic report_mismatch(input string what, input longint exp, input longint act);
      $display("Mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      test_errors++;
   endtask

   task automatic report_failure(input string msg);
      $display("Error in %s: %s", cur_test, msg);
      test_errors++;
   endtask

   task automatic write_reg(input logic [7:0] addr, input logic [6:0] cnt, input logic [7:0] d);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_bytecnt_i <= cnt;
      reg_datai_i <= d;
      reg_write_i <= 1'b1;
      @(posedge clk_usb);
      reg_write_i <= 1'b0;
   endtask

   task automatic read_reg(input logic [7:0] addr, input logic [6:0] cnt, output logic [7:0] d);
      @(posedge clk_usb);
      reg_address_i <= addr;
      reg_bytecnt_i <= cnt;
      @(negedge clk_usb);
      d = reg_datao_o;   // mux output is combinational
   endtask

   task automatic read_freq(output logic [31:0] f);
      logic [7:0] b;
      for (int i = 0; i < 4; i++) begin
         read_reg(openadc_pkg::addr_extclk_freq, i, b);
         f[8*i +: 8] = b;
      end
   endtask

   task automatic wait_gates(input int n);
      int start;
      int waited;
      start = gate_count;
      waited = 0;
      while (gate_count < start + n && waited < (n + 1) * gate_cycles) begin
         @(posedge clk_usb);
         waited++;
      end
      if (gate_count < start + n)
         report_failure("timebase gave no gate pulse");
   endtask

   task automatic drive_samples(input int r);
      logic [11:0] noise;
      for (int i = 0; i < 8; i++) begin
         take_noise(2, noise);   // margins in the table exceed 3
         @(posedge clk_usb);
         adc_data_i <= vec_samples[r][i] + noise;
      end
   endtask

   task automatic run_trigger_row(input int r);
      logic [11:0] idle;
      logic [7:0]  status;
      logic [1:0]  exp_bits;
      int          waited;
      start_test(vec_name[r]);
      idle = vec_level[r][11] ? 12'h000 : 12'hff0;   // never meets the new level
      @(posedge clk_usb);
      adc_data_i <= idle;
      write_reg(openadc_pkg::addr_settings, 0, {6'b0, vec_source[r], 1'b0});
      write_reg(openadc_pkg::addr_trig_level, 0, vec_level[r][7:0]);
      write_reg(openadc_pkg::addr_trig_level, 1, {4'b0, vec_level[r][11:8]});
      repeat (4) @(posedge clk_usb);   // stray hit on the old level drains here
      trig_count = 0;
      write_reg(openadc_pkg::addr_arm, 0, 8'h01);
      if (vec_source[r]) begin
         status = '0;
         waited = 0;
         while (!status[0] && waited < 8) begin
            read_reg(openadc_pkg::addr_status, 0, status);
            waited++;
         end
         if (!status[0])
            report_failure("status never showed armed");
         drive_samples(r);
         @(posedge clk_usb);
         adc_data_i <= idle;
      end
      waited = 0;
      while (trig_count < vec_trig[r] && waited < (vec_source[r] ? 16 : 4200)) begin
         @(posedge clk_usb);
         waited++;
      end
      repeat (4) @(posedge clk_usb);
      if (trig_count != vec_trig[r])
         report_mismatch("trigger pulses", vec_trig[r], trig_count);
      read_reg(openadc_pkg::addr_status, 0, status);
      exp_bits = {vec_trig[r] == 1, vec_trig[r] == 0};   // triggered, armed
      if (status[1:0] != exp_bits)
         report_mismatch("status armed and triggered", exp_bits, status[1:0]);
      if (vec_trig[r] == 1) begin
         if (vec_source[r]) begin
            drive_samples(r);
            @(posedge clk_usb);
            adc_data_i <= idle;
         end else begin
            repeat (64) @(posedge clk_usb);
         end
         repeat (4) @(posedge clk_usb);
         if (trig_count != 1)
            report_mismatch("pulses after one-shot", 1, trig_count);
      end
      finish_test();
   endtask

   initial begin
      logic [7:0]  d;
      logic [31:0] f;
      int          exp_f;
      int          waited;
      int          highs;
      reset = 1'b1;
      adc_data_i = '0;
      ext_clk_i = 1'b0;
      pll_status_i = 1'b0;
      reg_address_i = '0;
      reg_bytecnt_i = '0;
      reg_datai_i = '0;
      reg_write_i = 1'b0;
      tests_run = 0;
      tests_failed = 0;
      repeat (7) @(posedge clk_usb);
      @(negedge clk_usb);

      start_test("register_readback");
      if (reset_o != 1'b1)
         report_mismatch("reset_o while reset is held", 1, reset_o);
      @(posedge clk_usb);
      reset <= 1'b0;
      @(negedge clk_usb);
      if ({reset_o, trigger_adc_o, freq_measure_o, amp_gain_o} != 4'b0000)
         report_mismatch("outputs after reset", 0,
                         {reset_o, trigger_adc_o, freq_measure_o, amp_gain_o});
      for (int i = 0; i < num_regs; i++)
         write_reg(regs_addr[i], regs_cnt[i], regs_data[i]);
      for (int i = 0; i < num_regs; i++) begin
         read_reg(regs_addr[i], regs_cnt[i], d);
         if (d != regs_data[i])
            report_mismatch($sformatf("register %0h byte %0d", regs_addr[i], regs_cnt[i]),
                            regs_data[i], d);
      end
      write_reg(openadc_pkg::addr_settings, 0, 8'h01);   // soft reset
      @(negedge clk_usb);
      if (reset_o != 1'b1)
         report_mismatch("reset_o after soft reset write", 1, reset_o);
      for (int i = 0; i < num_regs; i++) begin
         read_reg(regs_addr[i], regs_cnt[i], d);
         if (d != 8'h00)
            report_mismatch($sformatf("register %0h after soft reset", regs_addr[i]), 0, d);
      end
      read_reg(openadc_pkg::addr_settings, 0, d);
      if (d != 8'h00)
         report_mismatch("settings after soft reset", 0, d);
      finish_test();

      for (int r = 0; r < num_rows; r++)
         run_trigger_row(r);

      start_test("extclk_freq");
      for (int i = 0; i < 4; i++)
         write_reg(openadc_pkg::addr_extclk_limit, i, (i == 0) ? 8'd8 : 8'd0);
      write_reg(openadc_pkg::addr_settings, 0, 8'h06);   // clear any old flag
      write_reg(openadc_pkg::addr_settings, 0, 8'h02);
      wait_gates(3);
      read_freq(f);
      exp_f = gate_cycles * clk_period / (2 * ext_half * clk_period);
      if (f > exp_f + 2 || f + 2 < exp_f)
         report_mismatch("frequency count", exp_f, f);
      read_reg(openadc_pkg::addr_status, 0, d);
      if (d[openadc_pkg::status_extclk_change] != 1'b0)
         report_mismatch("change flag at steady clock", 0, 1);
      finish_test();

      start_test("extclk_change");
      ext_half = 4;
      d = '0;
      waited = 0;
      while (!d[openadc_pkg::status_extclk_change] && waited < 4 * gate_cycles) begin
         read_reg(openadc_pkg::addr_status, 0, d);
         waited++;
      end
      if (!d[openadc_pkg::status_extclk_change])
         report_failure("change flag never set after the clock rate moved");
      write_reg(openadc_pkg::addr_led_select, 0, openadc_pkg::led_extclk);
      for (int i = 0; i < 32; i++) begin
         @(negedge clk_usb);
         if (led_armed_o != flash_pattern_o || led_capture_o != flash_pattern_o)
            report_mismatch("leds during clock alarm", {flash_pattern_o, flash_pattern_o},
                            {led_armed_o, led_capture_o});
      end
      wait_gates(2);
      read_freq(f);
      exp_f = gate_cycles * clk_period / (2 * ext_half * clk_period);
      if (f > exp_f + 2 || f + 2 < exp_f)
         report_mismatch("frequency count after change", exp_f, f);
      write_reg(openadc_pkg::addr_settings, 0, 8'h06);
      read_reg(openadc_pkg::addr_status, 0, d);
      if (d[openadc_pkg::status_extclk_change] != 1'b0)
         report_mismatch("change flag after monitor disable", 0, 1);
      write_reg(openadc_pkg::addr_settings, 0, 8'h02);
      write_reg(openadc_pkg::addr_led_select, 0, openadc_pkg::led_normal);
      finish_test();

      for (int g = 0; g < 5; g++) begin
         start_test($sformatf("pwm_gain_%0d", pwm_gains[g]));
         write_reg(openadc_pkg::addr_gain, 0, pwm_gains[g]);
         repeat (2) @(posedge clk_usb);   // accumulator picks up new gain
         highs = 0;
         for (int i = 0; i < 256; i++) begin
            @(negedge clk_usb);
            if (amp_gain_o)
               highs++;
         end
         if (highs != pwm_gains[g])
            report_mismatch("amp gain high cycles", pwm_gains[g], highs);
         finish_test();
      end

      $display("%0d tests run, %0d failed", tests_run, tests_failed);
      if (tests_failed == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

// ==== filelist.f ====
+incdir+tests
design/openadc_pkg.sv
design/adc_reg_bank.sv
design/adc_timebase.sv
design/extclk_monitor.sv
design/adc_level_trigger.sv
design/panel_drive.sv
design/openadc_interface.sv
tests/tb_openadc_interface.sv
